//--- include/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// chip-select window, matched against the top address byte
`define DMA_CS_ADDR 8'h50
`define DMA_CS_WIDTH 8

// sample buffer address width (2**N samples)
`define DMA_SRC_AW 3

// register index, address bits 4:2
`define DMA_REG_ADDR 3'd0
`define DMA_REG_STEP 3'd1
`define DMA_REG_CYCLES 3'd2
`define DMA_REG_BLOCKS 3'd3
`define DMA_REG_START 3'd4
`define DMA_REG_STOP 3'd5
`define DMA_REG_STATUS 3'd6

`endif

//--- src/dma_pkg.sv
package dma_pkg;

    // full bus word, data or address
    typedef logic [31:0] bus_word_t;

    // target byte address
    typedef logic [23:0] dma_addr_t;

    // step, cycles and blocks counts
    typedef logic [15:0] count_t;

    // one source sample
    typedef logic [15:0] sample_t;

    // register index from address bits 4:2
    typedef logic [2:0] reg_idx_t;

    // engine sequencer
    typedef enum logic [2:0] {
        idle,
        wait_block,
        request,
        wait_ack,
        block_end
    } engine_state_t;

endpackage

//--- src/chip_select.sv
`timescale 1ns/10ps

module chip_select #(
    parameter logic [7:0] ADDR = 8'h00,
    parameter int WIDTH = 8
) (
    input  logic       wb_clk,
    input  logic       wb_rst,
    input  logic [7:0] addr,
    input  logic       wb_cyc,
    output logic       cyc,
    output logic       ack
);

    // set once the current access has been acked
    logic acked;

    // only the top WIDTH bits take part in the match
    assign cyc = wb_cyc && (addr[7 -: WIDTH] == ADDR[7 -: WIDTH]);

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            ack   <= 1'b0;
            acked <= 1'b0;
        end else begin
            ack <= cyc && !acked;
            // rearm only once the master lets go of cyc
            if (!wb_cyc) begin
                acked <= 1'b0;
            end else if (cyc) begin
                acked <= 1'b1;
            end
        end
    end

endmodule

//--- src/dma_regs.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

module dma_regs (
    input  logic                wb_clk,
    input  logic                wb_rst,
    input  logic                cs_cyc,
    input  logic                cs_ack,
    input  logic                wb_dbus_we,
    input  dma_pkg::bus_word_t  wb_dbus_adr,
    input  dma_pkg::bus_word_t  wb_dbus_dat,
    output dma_pkg::bus_word_t  dbus_rdt,
    input  logic                block_done,
    input  logic                xfer_done,
    output dma_pkg::dma_addr_t  reg_addr,
    output dma_pkg::count_t     reg_step,
    output dma_pkg::count_t     reg_cycles,
    output dma_pkg::count_t     reg_blocks,
    output logic                start_req
);

    import dma_pkg::*;

    reg_idx_t  idx;
    bus_word_t rd_word;

    assign idx = wb_dbus_adr[4:2];

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            reg_addr   <= '0;
            reg_step   <= '0;
            reg_cycles <= '0;
            reg_blocks <= '0;
            start_req  <= 1'b0;
        end else if (cs_cyc && wb_dbus_we) begin
            case (idx)
                `DMA_REG_ADDR: begin
                    reg_addr <= wb_dbus_dat[23:0];
                end
                `DMA_REG_STEP: begin
                    reg_step <= wb_dbus_dat[15:0];
                end
                `DMA_REG_CYCLES: begin
                    reg_cycles <= wb_dbus_dat[15:0];
                end
                `DMA_REG_BLOCKS: begin
                    reg_blocks <= wb_dbus_dat[15:0];
                end
                // start and stop are strobes, the data word is ignored
                `DMA_REG_START: begin
                    start_req <= 1'b1;
                end
                `DMA_REG_STOP: begin
                    start_req <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // read mux, registers zero-extended to the bus width
    always_comb begin
        rd_word = '0;
        case (idx)
            `DMA_REG_ADDR:   rd_word = {8'h00, reg_addr};
            `DMA_REG_STEP:   rd_word = {16'h0000, reg_step};
            `DMA_REG_CYCLES: rd_word = {16'h0000, reg_cycles};
            `DMA_REG_BLOCKS: rd_word = {16'h0000, reg_blocks};
            `DMA_REG_STATUS: rd_word = {30'd0, block_done, xfer_done};
            default:         rd_word = '0;
        endcase
    end

    // data only in the ack cycle of a read
    assign dbus_rdt = (cs_ack && !wb_dbus_we) ? rd_word : '0;

endmodule

//--- src/dma_engine.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

module dma_engine (
    input  logic                   wb_clk,
    input  logic                   wb_rst,
    input  dma_pkg::dma_addr_t     reg_addr,
    input  dma_pkg::count_t        reg_step,
    input  dma_pkg::count_t        reg_cycles,
    input  dma_pkg::count_t        reg_blocks,
    input  logic                   start_req,
    input  logic                   xfer_block,
    output logic                   block_done,
    output logic                   xfer_done,
    output logic [`DMA_SRC_AW-1:0] xfer_adr,
    output logic                   xfer_re,
    input  dma_pkg::sample_t       xfer_dat,
    output logic                   dma_cyc,
    output logic                   dma_we,
    output logic [3:0]             dma_sel,
    output dma_pkg::bus_word_t     dma_adr,
    output dma_pkg::bus_word_t     dma_dat,
    input  logic                   dma_ack
);

    import dma_pkg::*;

    localparam int SRC_AW = `DMA_SRC_AW;

    engine_state_t state;
    dma_addr_t     run_base;
    count_t        run_cycles;
    dma_addr_t     cur_addr;
    count_t        remaining;
    bus_word_t     lane;
    logic          block_start;

    // a held xfer_block chains straight into the next block
    assign block_start = start_req && xfer_block &&
                         ((state == wait_block && !xfer_done) ||
                          (state == block_end && run_cycles != '0));

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            state      <= idle;
            run_base   <= '0;
            run_cycles <= '0;
            cur_addr   <= '0;
            remaining  <= '0;
            xfer_adr   <= '0;
            block_done <= 1'b0;
            xfer_done  <= 1'b0;
            dma_cyc    <= 1'b0;
            dma_we     <= 1'b0;
            dma_sel    <= 4'b0000;
            dma_adr    <= '0;
        end else begin
            if (!start_req) begin
                block_done <= 1'b0;
                xfer_done  <= 1'b0;
            end
            if (block_start) begin
                remaining  <= reg_blocks;
                cur_addr   <= run_base;
                xfer_adr   <= '0;
                block_done <= 1'b0;
                state      <= request;
            end else begin
                case (state)
                    idle: begin
                        if (start_req) begin
                            run_base   <= reg_addr;
                            run_cycles <= reg_cycles;
                            state      <= wait_block;
                        end
                    end
                    wait_block: begin
                        if (!start_req) begin
                            state <= idle;
                        end
                    end
                    request: begin
                        if (!start_req) begin
                            state <= idle;
                        end else if (remaining == '0) begin
                            // block finished, next one starts one halfword on
                            run_base <= run_base + 24'd2;
                            if (run_cycles != '0) begin
                                run_cycles <= run_cycles - 16'd1;
                            end
                            state <= block_end;
                        end else begin
                            dma_cyc <= 1'b1;
                            dma_we  <= 1'b1;
                            dma_sel <= cur_addr[1] ? 4'b1100 : 4'b0011;
                            dma_adr <= {8'h00, cur_addr[23:2], 2'b00};
                            state   <= wait_ack;
                        end
                    end
                    wait_ack: begin
                        // bus request stays put until the target acks
                        if (dma_ack) begin
                            dma_cyc   <= 1'b0;
                            dma_we    <= 1'b0;
                            dma_sel   <= 4'b0000;
                            dma_adr   <= '0;
                            cur_addr  <= cur_addr + dma_addr_t'(reg_step);
                            xfer_adr  <= xfer_adr + SRC_AW'(1);
                            remaining <= remaining - 16'd1;
                            state     <= start_req ? request : idle;
                        end
                    end
                    block_end: begin
                        if (!start_req) begin
                            state <= idle;
                        end else if (!xfer_block) begin
                            block_done <= 1'b1;
                            xfer_done  <= (run_cycles == '0);
                            state      <= wait_block;
                        end
                    end
                    default: begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

    // sample goes into the halfword picked by address bit 1
    assign lane = cur_addr[1] ? {xfer_dat, 16'h0000} : {16'h0000, xfer_dat};

    assign xfer_re = (state == wait_ack) && dma_ack;
    assign dma_dat = xfer_re ? lane : '0;

endmodule

//--- src/sample_buffer.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

module sample_buffer (
    input  logic                   wb_clk,
    input  logic                   load_we,
    input  logic [`DMA_SRC_AW-1:0] load_adr,
    input  dma_pkg::sample_t       load_dat,
    input  logic [`DMA_SRC_AW-1:0] xfer_adr,
    input  logic                   xfer_re,
    output dma_pkg::sample_t       xfer_dat
);

    import dma_pkg::*;

    localparam int DEPTH = 1 << `DMA_SRC_AW;

    sample_t mem [DEPTH];

    // external fill port
    always_ff @(posedge wb_clk) begin
        if (load_we) begin
            mem[load_adr] <= load_dat;
        end
    end

    // same-cycle read, only presented while the engine consumes it
    assign xfer_dat = xfer_re ? mem[xfer_adr] : '0;

endmodule

//--- src/dma_subsystem.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

module dma_subsystem (
    input  logic                   wb_clk,
    input  logic                   wb_rst,
    // cpu slave side
    input  logic                   wb_dbus_cyc,
    input  logic                   wb_dbus_we,
    input  dma_pkg::bus_word_t     wb_dbus_adr,
    input  dma_pkg::bus_word_t     wb_dbus_dat,
    output dma_pkg::bus_word_t     dbus_rdt,
    output logic                   dbus_ack,
    // block control
    input  logic                   xfer_block,
    output logic                   block_done,
    output logic                   xfer_done,
    // master write bus
    output logic                   dma_cyc,
    output logic                   dma_we,
    output logic [3:0]             dma_sel,
    output dma_pkg::bus_word_t     dma_adr,
    output dma_pkg::bus_word_t     dma_dat,
    input  logic                   dma_ack,
    // sample buffer fill
    input  logic                   load_we,
    input  logic [`DMA_SRC_AW-1:0] load_adr,
    input  dma_pkg::sample_t       load_dat
);

    import dma_pkg::*;

    logic                   cs_cyc;
    dma_addr_t              reg_addr;
    count_t                 reg_step;
    count_t                 reg_cycles;
    count_t                 reg_blocks;
    logic                   start_req;
    logic [`DMA_SRC_AW-1:0] xfer_adr;
    logic                   xfer_re;
    sample_t                xfer_dat;

    chip_select #(
        .ADDR(`DMA_CS_ADDR),
        .WIDTH(`DMA_CS_WIDTH)
    ) i_cs (
        .wb_clk(wb_clk),
        .wb_rst(wb_rst),
        .addr(wb_dbus_adr[31:24]),
        .wb_cyc(wb_dbus_cyc),
        .cyc(cs_cyc),
        .ack(dbus_ack)
    );

    dma_regs i_regs (
        .wb_clk(wb_clk),
        .wb_rst(wb_rst),
        .cs_cyc(cs_cyc),
        .cs_ack(dbus_ack),
        .wb_dbus_we(wb_dbus_we),
        .wb_dbus_adr(wb_dbus_adr),
        .wb_dbus_dat(wb_dbus_dat),
        .dbus_rdt(dbus_rdt),
        .block_done(block_done),
        .xfer_done(xfer_done),
        .reg_addr(reg_addr),
        .reg_step(reg_step),
        .reg_cycles(reg_cycles),
        .reg_blocks(reg_blocks),
        .start_req(start_req)
    );

    dma_engine i_engine (
        .wb_clk(wb_clk),
        .wb_rst(wb_rst),
        .reg_addr(reg_addr),
        .reg_step(reg_step),
        .reg_cycles(reg_cycles),
        .reg_blocks(reg_blocks),
        .start_req(start_req),
        .xfer_block(xfer_block),
        .block_done(block_done),
        .xfer_done(xfer_done),
        .xfer_adr(xfer_adr),
        .xfer_re(xfer_re),
        .xfer_dat(xfer_dat),
        .dma_cyc(dma_cyc),
        .dma_we(dma_we),
        .dma_sel(dma_sel),
        .dma_adr(dma_adr),
        .dma_dat(dma_dat),
        .dma_ack(dma_ack)
    );

    sample_buffer i_buf (
        .wb_clk(wb_clk),
        .load_we(load_we),
        .load_adr(load_adr),
        .load_dat(load_dat),
        .xfer_adr(xfer_adr),
        .xfer_re(xfer_re),
        .xfer_dat(xfer_dat)
    );

endmodule

//--- testbench/dma_chk.sv
`timescale 1ns/10ps

module dma_chk (
    input logic               wb_clk,
    input logic               wb_rst,
    input logic               dma_cyc,
    input logic               dma_we,
    input logic [3:0]         dma_sel,
    input dma_pkg::bus_word_t dma_adr,
    input logic               dma_ack,
    input logic               xfer_re,
    input logic               dbus_ack,
    input logic               block_done,
    input logic               xfer_done
);

    // failed assertions so far
    int fail_count = 0;

    // master request frozen while the target stalls
    stable_request: assert property (@(posedge wb_clk) disable iff (wb_rst)
        dma_cyc && !dma_ack |=> $stable({dma_cyc, dma_we, dma_sel, dma_adr}))
    else begin
        fail_count++;
        $error("master request changed before dma_ack");
    end

    // exactly one source read for each acked master write
    read_with_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
        xfer_re == (dma_cyc && dma_ack))
    else begin
        fail_count++;
        $error("xfer_re out of step with the acked master write");
    end

    single_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
        dbus_ack |=> !dbus_ack)
    else begin
        fail_count++;
        $error("dbus_ack held for more than one cycle");
    end

    reset_state: assert property (@(posedge wb_clk)
        wb_rst |=> !block_done && !xfer_done && !dma_cyc && !dbus_ack)
    else begin
        fail_count++;
        $error("done flags or bus strobes high after reset");
    end

endmodule

bind dma_subsystem dma_chk i_chk (
    .wb_clk(wb_clk),
    .wb_rst(wb_rst),
    .dma_cyc(dma_cyc),
    .dma_we(dma_we),
    .dma_sel(dma_sel),
    .dma_adr(dma_adr),
    .dma_ack(dma_ack),
    .xfer_re(xfer_re),
    .dbus_ack(dbus_ack),
    .block_done(block_done),
    .xfer_done(xfer_done)
);

//--- testbench/tb_dma.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

module tb_dma;

    import dma_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int SRC_DEPTH = 1 << `DMA_SRC_AW;
    localparam int ACCESS_CYCLES = 8;
    // slowest ack plus the idle gap
    localparam int XFER_CYCLES = 12;
    localparam int BLOCK_CYCLES = 4 * XFER_CYCLES + 10;
    localparam int TEST_CYCLES = 30 * (ACCESS_CYCLES + 2) + 20 * XFER_CYCLES + 100;
    localparam int MARGIN = 4;

    logic                   wb_clk;
    logic                   wb_rst;
    logic                   wb_dbus_cyc;
    logic                   wb_dbus_we;
    bus_word_t              wb_dbus_adr;
    bus_word_t              wb_dbus_dat;
    bus_word_t              dbus_rdt;
    logic                   dbus_ack;
    logic                   xfer_block;
    logic                   block_done;
    logic                   xfer_done;
    logic                   dma_cyc;
    logic                   dma_we;
    logic [3:0]             dma_sel;
    bus_word_t              dma_adr;
    bus_word_t              dma_dat;
    logic                   dma_ack;
    logic                   load_we;
    logic [`DMA_SRC_AW-1:0] load_adr;
    sample_t                load_dat;

    sample_t    samples [SRC_DEPTH];
    bus_word_t  exp_adr [$];
    logic [3:0] exp_sel [$];
    bus_word_t  exp_dat [$];
    logic [15:0] lfsr;
    logic       slow_acks;
    int         ack_count;
    int         checks;
    int         errors;
    int         tests_run;
    int         errors_before;

    dma_subsystem i_dut (.*);

    initial begin
        wb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    end

    // galois form, one step per returned bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic bus_word_t reg_adr(input reg_idx_t idx);
        return {`DMA_CS_ADDR, 19'd0, idx, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errors == errors_before) ? "ok" : "failed", errors - errors_before);
        errors_before = errors;
    endtask

    // one cpu access, cyc held until ack or timeout
    task automatic cpu_access(input logic we, input bus_word_t adr, input bus_word_t dat,
                              output bus_word_t rdt, output logic acked);
        int waited;
        rdt = '0;
        acked = 1'b0;
        waited = 0;
        @(posedge wb_clk);
        #2;
        wb_dbus_cyc = 1'b1;
        wb_dbus_we = we;
        wb_dbus_adr = adr;
        wb_dbus_dat = dat;
        while (!acked && waited < ACCESS_CYCLES) begin
            @(negedge wb_clk);
            if (dbus_ack) begin
                acked = 1'b1;
                rdt = dbus_rdt;
            end
            waited++;
        end
        @(posedge wb_clk);
        #2;
        wb_dbus_cyc = 1'b0;
        wb_dbus_we = 1'b0;
    endtask

    task automatic reg_write(input reg_idx_t idx, input bus_word_t dat);
        bus_word_t rdt;
        logic acked;
        cpu_access(1'b1, reg_adr(idx), dat, rdt, acked);
        check_true(acked, $sformatf("no ack for the write to register %0d", idx));
    endtask

    task automatic reg_read_check(input reg_idx_t idx, input bus_word_t exp, input string name);
        bus_word_t rdt;
        logic acked;
        cpu_access(1'b0, reg_adr(idx), '0, rdt, acked);
        check_true(acked, $sformatf("no ack for the read of register %0d", idx));
        check_value(name, rdt, exp);
    endtask

    task automatic load_samples();
        for (int a = 0; a < SRC_DEPTH; a++) begin
            @(posedge wb_clk);
            #2;
            load_we = 1'b1;
            load_adr = a[`DMA_SRC_AW-1:0];
            load_dat = sample_t'(lfsr_bits(16));
            samples[load_adr] = load_dat;
        end
        @(posedge wb_clk);
        #2;
        load_we = 1'b0;
    endtask

    // expected writes: block k starts at base + 2k, transfer i adds i steps
    task automatic queue_run(input dma_addr_t base, input count_t step,
                             input int cycles, input int blocks);
        dma_addr_t cur;
        sample_t s;
        logic [`DMA_SRC_AW-1:0] sidx;
        for (int k = 0; k < cycles; k++) begin
            for (int i = 0; i < blocks; i++) begin
                cur = base + 24'(2 * k) + 24'(step) * 24'(i);
                sidx = i[`DMA_SRC_AW-1:0];
                s = samples[sidx];
                exp_adr.push_back({8'h00, cur[23:2], 2'b00});
                exp_sel.push_back(cur[1] ? 4'b1100 : 4'b0011);
                exp_dat.push_back(cur[1] ? {s, 16'h0000} : {16'h0000, s});
            end
        end
    endtask

    // target memory, random wait cycles before the ack
    task automatic serve_write();
        int waits;
        waits = int'(lfsr_bits(2)) + (slow_acks ? 4 : 0);
        repeat (waits) begin
            @(posedge wb_clk);
            #2;
        end
        dma_ack = 1'b1;
        @(negedge wb_clk);
        ack_count++;
        if (exp_adr.size() == 0) begin
            check_true(1'b0, $sformatf("unexpected master write to address %h", dma_adr));
        end else begin
            check_value("dma_adr", dma_adr, exp_adr.pop_front());
            check_value("dma_sel", 32'(dma_sel), 32'(exp_sel.pop_front()));
            check_value("dma_dat", dma_dat, exp_dat.pop_front());
            check_value("dma_we", 32'(dma_we), 32'd1);
        end
        @(posedge wb_clk);
        #2;
        dma_ack = 1'b0;
    endtask

    initial begin : target_memory
        forever begin
            @(posedge wb_clk);
            #2;
            if (dma_cyc && !wb_rst) begin
                serve_write();
            end
        end
    end

    task automatic pulse_block();
        @(posedge wb_clk);
        #2;
        xfer_block = 1'b1;
        @(posedge wb_clk);
        #2;
        xfer_block = 1'b0;
    endtask

    task automatic run_block(input int blocks, input logic last);
        int acks_before;
        int waited;
        acks_before = ack_count;
        waited = 0;
        pulse_block();
        do begin
            @(negedge wb_clk);
            waited++;
        end while (!block_done && waited < BLOCK_CYCLES);
        check_true(block_done, "block_done did not rise within the block timeout");
        check_value("acks before block_done", 32'(ack_count - acks_before), 32'(blocks));
        check_value("xfer_done", 32'(xfer_done), 32'(last));
    endtask

    initial begin : watchdog
        #(CLK_PERIOD * TEST_CYCLES * MARGIN);
        $display("watchdog expired after %0d cycles", TEST_CYCLES * MARGIN);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main
        bus_word_t rdt;
        logic acked;
        int acks_before;
        wb_rst = 1'b1;
        wb_dbus_cyc = 1'b0;
        wb_dbus_we = 1'b0;
        wb_dbus_adr = '0;
        wb_dbus_dat = '0;
        xfer_block = 1'b0;
        dma_ack = 1'b0;
        load_we = 1'b0;
        load_adr = '0;
        load_dat = '0;
        lfsr = 16'd24243;
        slow_acks = 1'b0;
        ack_count = 0;
        checks = 0;
        errors = 0;
        tests_run = 0;
        errors_before = 0;
        repeat (8) @(posedge wb_clk);
        #2;
        wb_rst = 1'b0;

        reg_read_check(`DMA_REG_STATUS, 32'h0, "dbus_rdt status");
        reg_write(`DMA_REG_ADDR, 32'hA512_3456);
        reg_write(`DMA_REG_STEP, 32'hFFFF_1234);
        reg_write(`DMA_REG_CYCLES, 32'h7777_0003);
        reg_write(`DMA_REG_BLOCKS, 32'h8000_0004);
        reg_read_check(`DMA_REG_ADDR, 32'h0012_3456, "dbus_rdt addr");
        reg_read_check(`DMA_REG_STEP, 32'h0000_1234, "dbus_rdt step");
        reg_read_check(`DMA_REG_CYCLES, 32'h0000_0003, "dbus_rdt cycles");
        reg_read_check(`DMA_REG_BLOCKS, 32'h0000_0004, "dbus_rdt blocks");
        report_test("register readback");

        // top byte 0x40 misses the window
        cpu_access(1'b1, {8'h40, 19'd0, `DMA_REG_ADDR, 2'b00}, 32'h00AB_CDEF, rdt, acked);
        check_true(!acked, "write outside the window was acked");
        cpu_access(1'b0, {8'h40, 19'd0, `DMA_REG_STEP, 2'b00}, 32'h0, rdt, acked);
        check_true(!acked, "read outside the window was acked");
        reg_read_check(`DMA_REG_ADDR, 32'h0012_3456, "dbus_rdt addr");
        report_test("window decode");

        // odd halfword step so sel alternates
        load_samples();
        reg_write(`DMA_REG_ADDR, 32'h0000_0100);
        reg_write(`DMA_REG_STEP, 32'h0000_0006);
        reg_write(`DMA_REG_CYCLES, 32'h0000_0003);
        reg_write(`DMA_REG_BLOCKS, 32'h0000_0004);
        queue_run(24'h000100, 16'd6, 3, 4);
        reg_write(`DMA_REG_START, 32'h0);
        run_block(4, 1'b0);
        report_test("master write sequence");

        run_block(4, 1'b0);
        report_test("block boundaries");

        run_block(4, 1'b1);
        acks_before = ack_count;
        pulse_block();
        repeat (4 * XFER_CYCLES) @(negedge wb_clk);
        check_value("acks after xfer_done", 32'(ack_count), 32'(acks_before));
        check_value("pending writes", 32'(exp_adr.size()), 32'd0);
        report_test("transfer done");

        reg_write(`DMA_REG_STOP, 32'h0);
        @(negedge wb_clk);
        check_value("block_done", 32'(block_done), 32'd0);
        check_value("xfer_done", 32'(xfer_done), 32'd0);
        reg_read_check(`DMA_REG_STATUS, 32'h0, "dbus_rdt status");
        reg_write(`DMA_REG_ADDR, 32'h0000_0202);
        reg_write(`DMA_REG_STEP, 32'h0000_0004);
        reg_write(`DMA_REG_CYCLES, 32'h0000_0002);
        reg_write(`DMA_REG_BLOCKS, 32'h0000_0003);
        slow_acks = 1'b1;
        queue_run(24'h000202, 16'd4, 2, 3);
        reg_write(`DMA_REG_START, 32'h0);
        run_block(3, 1'b0);
        run_block(3, 1'b1);
        check_value("pending writes", 32'(exp_adr.size()), 32'd0);
        report_test("stop and restart");

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, checks, errors, i_dut.i_chk.fail_count);
        if (errors == 0 && i_dut.i_chk.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
src/dma_pkg.sv
src/chip_select.sv
src/dma_regs.sv
src/dma_engine.sv
src/sample_buffer.sv
src/dma_subsystem.sv
testbench/dma_chk.sv
testbench/tb_dma.sv

//--- Makefile
TOP := tb_dma

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f filelist.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
